// ==== common/baser_pkg.sv ====
// ========================================
// Shared definitions of the BASE-R decoder
// Widths, sync headers, block type codes,
// MII characters and the block kind type
// ========================================
package baser_pkg;

    // Block and MII widths
    localparam int DATA_W = 64;
    localparam int HDR_W  = 2;
    localparam int LANES  = 8;

    // Sync header sits in the low bits, payload above it
    typedef logic [DATA_W+HDR_W-1:0] coded_t;
    typedef logic [DATA_W-1:0]       mii_data_t;
    typedef logic [LANES-1:0]        mii_ctrl_t;

    // Sync header values
    localparam logic [HDR_W-1:0] SH_DATA = 2'b10;
    localparam logic [HDR_W-1:0] SH_CTRL = 2'b01;

    // Block type field, first payload byte of a control block
    localparam logic [7:0] BT_CTRL  = 8'h1E;
    localparam logic [7:0] BT_START = 8'h78;
    localparam logic [7:0] BT_TERM0 = 8'h87;
    localparam logic [7:0] BT_TERM1 = 8'h99;
    localparam logic [7:0] BT_TERM2 = 8'hAA;
    localparam logic [7:0] BT_TERM3 = 8'hB4;
    localparam logic [7:0] BT_TERM4 = 8'hCC;
    localparam logic [7:0] BT_TERM5 = 8'hD2;
    localparam logic [7:0] BT_TERM6 = 8'hE1;
    localparam logic [7:0] BT_TERM7 = 8'hFF;

    // 7-bit idle character on the line
    localparam logic [6:0] CC_IDLE = 7'h00;

    // MII characters
    localparam logic [7:0] MII_IDLE  = 8'h07;
    localparam logic [7:0] MII_ERROR = 8'hFE;
    localparam logic [7:0] MII_START = 8'hFB;
    localparam logic [7:0] MII_TERM  = 8'hFD;

    typedef enum logic [2:0] {
        KIND_DATA,
        KIND_CTRL,
        KIND_START,
        KIND_TERM,
        KIND_BAD
    } blk_kind_t;

    // Lane of the terminate character
    typedef logic [2:0] term_pos_t;

endpackage

// ==== common/blk_if.sv ====
// ========================================
// Classified block bus between the
// classifier and the second stage
// ========================================
`timescale 1ns/100ps

interface blk_if;

    // One-cycle strobe per block
    logic                         valid;
    baser_pkg::blk_kind_t         kind;
    baser_pkg::term_pos_t         term_pos;
    // Payload without the sync header
    logic [baser_pkg::DATA_W-1:0] payload;
    logic                         sh_err;
    logic                         fmt_err;

    modport src (
        output valid, kind, term_pos, payload, sh_err, fmt_err
    );

    modport dst (
        input  valid, kind, term_pos, payload, sh_err, fmt_err
    );

endinterface

// ==== decode/block_classifier.sv ====
// ========================================
// Stage 1 of the receive decoder
// Sync header and block type checks,
// terminate padding check, block register
// ========================================
`timescale 1ns/100ps

module block_classifier (
    input  logic              clk,
    input  logic              i_rst,
    input  logic              i_valid,
    input  baser_pkg::coded_t i_rx_coded,
    blk_if.src                o_blk
);

    logic [baser_pkg::HDR_W-1:0]  sh;
    logic [baser_pkg::DATA_W-1:0] payload;
    logic [7:0]                   btype;
    logic                         is_term;
    baser_pkg::term_pos_t         term_pos_d;
    logic [2:0]                   pad_len;
    logic [6:0]                   pad_lo;
    logic [baser_pkg::DATA_W-1:0] pad_mask;
    logic                         pad_nz;
    baser_pkg::blk_kind_t         kind_d;
    logic                         sh_err_d;
    logic                         fmt_err_d;

    assign sh      = i_rx_coded[baser_pkg::HDR_W-1:0];
    assign payload = i_rx_coded[baser_pkg::HDR_W +: baser_pkg::DATA_W];
    assign btype   = payload[7:0];

    // Terminate type gives k data bytes before the T lane
    always_comb begin
        is_term    = 1'b1;
        term_pos_d = '0;
        case (btype)
            baser_pkg::BT_TERM0: term_pos_d = 3'd0;
            baser_pkg::BT_TERM1: term_pos_d = 3'd1;
            baser_pkg::BT_TERM2: term_pos_d = 3'd2;
            baser_pkg::BT_TERM3: term_pos_d = 3'd3;
            baser_pkg::BT_TERM4: term_pos_d = 3'd4;
            baser_pkg::BT_TERM5: term_pos_d = 3'd5;
            baser_pkg::BT_TERM6: term_pos_d = 3'd6;
            baser_pkg::BT_TERM7: term_pos_d = 3'd7;
            default:             is_term    = 1'b0;
        endcase
    end

    // 7-k unused bits follow the last data byte
    assign pad_len  = 3'(baser_pkg::LANES - 1) - term_pos_d;
    assign pad_lo   = {1'b0, term_pos_d, 3'b000} + 7'd8;
    assign pad_mask = (({{(baser_pkg::DATA_W-1){1'b0}}, 1'b1} << pad_len)
                       - {{(baser_pkg::DATA_W-1){1'b0}}, 1'b1}) << pad_lo;
    assign pad_nz   = |(payload & pad_mask);

    assign sh_err_d = (sh != baser_pkg::SH_DATA) && (sh != baser_pkg::SH_CTRL);

    always_comb begin
        kind_d    = baser_pkg::KIND_BAD;
        fmt_err_d = 1'b0;
        if (sh == baser_pkg::SH_DATA) begin
            kind_d = baser_pkg::KIND_DATA;
        end else if (sh == baser_pkg::SH_CTRL) begin
            if (btype == baser_pkg::BT_CTRL) begin
                kind_d = baser_pkg::KIND_CTRL;
            end else if (btype == baser_pkg::BT_START) begin
                kind_d = baser_pkg::KIND_START;
            end else if (is_term) begin
                // Bad padding is flagged but still decoded as terminate
                kind_d    = baser_pkg::KIND_TERM;
                fmt_err_d = pad_nz;
            end else begin
                fmt_err_d = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge i_rst) begin
        if (i_rst) begin
            o_blk.valid <= 1'b0;
        end else begin
            o_blk.valid <= i_valid;
        end
    end

    // Block fields load with each accepted block
    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_blk.kind     <= kind_d;
            o_blk.term_pos <= term_pos_d;
            o_blk.payload  <= payload;
            o_blk.sh_err   <= sh_err_d;
            o_blk.fmt_err  <= fmt_err_d;
        end
    end

endmodule

// ==== decode/mii_mapper.sv ====
// ========================================
// Stage 2 MII mapper
// Builds the MII data word and control
// mask from a classified block
// ========================================
`timescale 1ns/100ps

module mii_mapper (
    input  logic                 clk,
    input  logic                 i_rst,
    blk_if.dst                   i_blk,
    output logic                 o_valid,
    output baser_pkg::mii_data_t o_txd,
    output baser_pkg::mii_ctrl_t o_txc
);

    baser_pkg::mii_data_t         txd_d;
    baser_pkg::mii_ctrl_t         txc_d;
    // Terminate data bytes start after the type byte
    logic [baser_pkg::DATA_W-1:0] term_data;

    // Idle stays idle, anything else becomes an error
    function automatic logic [7:0] map_cc(input logic [6:0] cc);
        return (cc == baser_pkg::CC_IDLE) ? baser_pkg::MII_IDLE : baser_pkg::MII_ERROR;
    endfunction

    assign term_data = i_blk.payload >> 8;

    // Lane j control character sits at bit 8+7j for both control and terminate
    always_comb begin
        case (i_blk.kind)
            baser_pkg::KIND_DATA: begin
                txd_d = i_blk.payload;
                txc_d = '0;
            end
            baser_pkg::KIND_CTRL: begin
                for (int j = 0; j < baser_pkg::LANES; j++) begin
                    txd_d[8*j +: 8] = map_cc(i_blk.payload[8+7*j +: 7]);
                end
                txc_d = '1;
            end
            baser_pkg::KIND_START: begin
                txd_d = {i_blk.payload[baser_pkg::DATA_W-1:8], baser_pkg::MII_START};
                txc_d = 8'h01;
            end
            baser_pkg::KIND_TERM: begin
                for (int j = 0; j < baser_pkg::LANES; j++) begin
                    if (j < int'(i_blk.term_pos)) begin
                        txd_d[8*j +: 8] = term_data[8*j +: 8];
                    end else if (j == int'(i_blk.term_pos)) begin
                        txd_d[8*j +: 8] = baser_pkg::MII_TERM;
                    end else begin
                        txd_d[8*j +: 8] = map_cc(i_blk.payload[8+7*j +: 7]);
                    end
                end
                txc_d = {baser_pkg::LANES{1'b1}} << i_blk.term_pos;
            end
            default: begin
                txd_d = {baser_pkg::LANES{baser_pkg::MII_ERROR}};
                txc_d = '1;
            end
        endcase
    end

    always_ff @(posedge clk or posedge i_rst) begin
        if (i_rst) begin
            o_valid <= 1'b0;
            o_txd   <= '0;
            o_txc   <= '0;
        end else begin
            o_valid <= i_blk.valid;
            // Hold the last word between blocks
            if (i_blk.valid) begin
                o_txd <= txd_d;
                o_txc <= txc_d;
            end
        end
    end

endmodule

// ==== hdl/rx_stats.sv ====
// ========================================
// Stage 2 receive statistics
// Block, data, control and error counters
// ========================================
`timescale 1ns/100ps

module rx_stats #(
    parameter int CNT_W = 32
) (
    input  logic             clk,
    input  logic             i_rst,
    blk_if.dst               i_blk,
    output logic [CNT_W-1:0] o_block_count,
    output logic [CNT_W-1:0] o_data_count,
    output logic [CNT_W-1:0] o_ctrl_count,
    output logic [CNT_W-1:0] o_inv_format_count,
    output logic [CNT_W-1:0] o_inv_sh_count,
    output logic [CNT_W-1:0] o_inv_block_count
);

    logic is_data;
    logic is_ctrl;

    // Any block with a control header, unknown types included
    assign is_data = (i_blk.kind == baser_pkg::KIND_DATA);
    assign is_ctrl = !is_data && !i_blk.sh_err;

    always_ff @(posedge clk or posedge i_rst) begin
        if (i_rst) begin
            o_block_count      <= '0;
            o_data_count       <= '0;
            o_ctrl_count       <= '0;
            o_inv_format_count <= '0;
            o_inv_sh_count     <= '0;
            o_inv_block_count  <= '0;
        end else if (i_blk.valid) begin
            o_block_count <= o_block_count + CNT_W'(1);
            if (is_data) begin
                o_data_count <= o_data_count + CNT_W'(1);
            end
            if (is_ctrl) begin
                o_ctrl_count <= o_ctrl_count + CNT_W'(1);
            end
            if (i_blk.fmt_err) begin
                o_inv_format_count <= o_inv_format_count + CNT_W'(1);
            end
            if (i_blk.sh_err) begin
                o_inv_sh_count <= o_inv_sh_count + CNT_W'(1);
            end
            // Errors are exclusive per block, so this tracks their sum
            if (i_blk.fmt_err || i_blk.sh_err) begin
                o_inv_block_count <= o_inv_block_count + CNT_W'(1);
            end
        end
    end

endmodule

// ==== hdl/baser_rx_top.sv ====
// ========================================
// BASE-R 64B/66B receive decoder top
// Classifier, then MII mapper and
// statistics in parallel
// ========================================
`timescale 1ns/100ps

module baser_rx_top #(
    parameter int CNT_W = 32
) (
    input  logic                 clk,
    input  logic                 i_rst,
    input  logic                 i_valid,
    input  baser_pkg::coded_t    i_rx_coded,
    output logic                 o_valid,
    output baser_pkg::mii_data_t o_txd,
    output baser_pkg::mii_ctrl_t o_txc,
    output logic [CNT_W-1:0]     o_block_count,
    output logic [CNT_W-1:0]     o_data_count,
    output logic [CNT_W-1:0]     o_ctrl_count,
    output logic [CNT_W-1:0]     o_inv_format_count,
    output logic [CNT_W-1:0]     o_inv_sh_count,
    output logic [CNT_W-1:0]     o_inv_block_count
);

    // Stage 1 result, shared by both stage 2 blocks
    blk_if cls_blk ();

    block_classifier block_classifier_i (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_valid    (i_valid),
        .i_rx_coded (i_rx_coded),
        .o_blk      (cls_blk)
    );

    mii_mapper mii_mapper_i (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_blk   (cls_blk),
        .o_valid (o_valid),
        .o_txd   (o_txd),
        .o_txc   (o_txc)
    );

    rx_stats #(
        .CNT_W (CNT_W)
    ) rx_stats_i (
        .clk                (clk),
        .i_rst              (i_rst),
        .i_blk              (cls_blk),
        .o_block_count      (o_block_count),
        .o_data_count       (o_data_count),
        .o_ctrl_count       (o_ctrl_count),
        .o_inv_format_count (o_inv_format_count),
        .o_inv_sh_count     (o_inv_sh_count),
        .o_inv_block_count  (o_inv_block_count)
    );

endmodule

// ==== sim/baser_rx_assertions.sv ====
// ========================================
// Concurrent checks on the decoder top:
// output latency, error masks and
// counters that never go backwards
// ========================================
`timescale 1ns/100ps

module baser_rx_assertions #(
    parameter int CNT_W = 32
) (
    input logic                 clk,
    input logic                 i_rst,
    input logic                 i_valid,
    input logic                 o_valid,
    input baser_pkg::mii_ctrl_t o_txc,
    input logic [CNT_W-1:0]     o_block_count,
    input logic [CNT_W-1:0]     o_inv_format_count,
    input logic [CNT_W-1:0]     o_inv_sh_count,
    input logic [CNT_W-1:0]     o_inv_block_count
);

    int unsigned fail_count = 0;

    // Two register stages between input and output strobe
    a_valid_latency: assert property (@(posedge clk) disable iff (i_rst)
        o_valid == $past(i_valid, 2))
        else begin
            $error("o_valid does not follow i_valid by two cycles");
            fail_count++;
        end

    a_sh_err_mask: assert property (@(posedge clk) disable iff (i_rst)
        (o_inv_sh_count != $past(o_inv_sh_count)) |-> (o_txc == 8'hFF))
        else begin
            $error("sync header error without full control mask");
            fail_count++;
        end

    // A terminate with bad padding keeps its shifted mask, so lane 7 is always control
    a_fmt_err_mask: assert property (@(posedge clk) disable iff (i_rst)
        (o_inv_format_count != $past(o_inv_format_count)) |-> o_txc[7])
        else begin
            $error("format error with data in lane 7");
            fail_count++;
        end

    a_blocks_mono: assert property (@(posedge clk) disable iff (i_rst)
        o_block_count >= $past(o_block_count))
        else begin
            $error("block counter decreased");
            fail_count++;
        end

    a_inv_mono: assert property (@(posedge clk) disable iff (i_rst)
        o_inv_block_count >= $past(o_inv_block_count))
        else begin
            $error("invalid block counter decreased");
            fail_count++;
        end

endmodule

bind baser_rx_top baser_rx_assertions #(
    .CNT_W (CNT_W)
) baser_rx_assertions_i (
    .clk                (clk),
    .i_rst              (i_rst),
    .i_valid            (i_valid),
    .o_valid            (o_valid),
    .o_txc              (o_txc),
    .o_block_count      (o_block_count),
    .o_inv_format_count (o_inv_format_count),
    .o_inv_sh_count     (o_inv_sh_count),
    .o_inv_block_count  (o_inv_block_count)
);

// ==== sim/tb_baser_rx.sv ====
// ========================================
// Directed testbench of the BASE-R
// receive decoder: clock, reset, LFSR,
// test tasks, compare tasks and watchdog
// ========================================
`timescale 1ns/100ps

module tb_baser_rx;

    localparam int CNT_W       = 32;
    localparam int CLK_PERIOD  = 4;
    localparam int DRAIN_CYC   = 20;
    // Blocks sent over all tests
    localparam int TEST_BLOCKS = 42;
    // Margin for reset, gaps and drains
    localparam int MARGIN_CYC  = 200;
    localparam logic [7:0] TERM_TYPES [8] = '{
        baser_pkg::BT_TERM0, baser_pkg::BT_TERM1, baser_pkg::BT_TERM2, baser_pkg::BT_TERM3,
        baser_pkg::BT_TERM4, baser_pkg::BT_TERM5, baser_pkg::BT_TERM6, baser_pkg::BT_TERM7
    };

    logic                 clk = 1'b0;
    logic                 i_rst;
    logic                 i_valid;
    baser_pkg::coded_t    i_rx_coded;
    logic                 o_valid;
    baser_pkg::mii_data_t o_txd;
    baser_pkg::mii_ctrl_t o_txc;
    logic [CNT_W-1:0]     o_block_count;
    logic [CNT_W-1:0]     o_data_count;
    logic [CNT_W-1:0]     o_ctrl_count;
    logic [CNT_W-1:0]     o_inv_format_count;
    logic [CNT_W-1:0]     o_inv_sh_count;
    logic [CNT_W-1:0]     o_inv_block_count;

    baser_pkg::mii_data_t exp_txd_q[$];
    baser_pkg::mii_ctrl_t exp_txc_q[$];
    // Counter model
    logic [CNT_W-1:0]     m_blocks = '0;
    logic [CNT_W-1:0]     m_data = '0;
    logic [CNT_W-1:0]     m_ctrl = '0;
    logic [CNT_W-1:0]     m_fmt = '0;
    logic [CNT_W-1:0]     m_sh = '0;
    logic [CNT_W-1:0]     m_inv = '0;
    baser_pkg::mii_data_t last_txd = '0;
    baser_pkg::mii_ctrl_t last_txc = '0;
    logic [CNT_W-1:0]     last_blocks = '0;
    logic [31:0]          lfsr_state = 32'h7f27_d45d;
    string                cur_test = "init";
    int                   err_count = 0;
    int                   test_errs = 0;
    int                   tests_run = 0;
    int                   tests_failed = 0;

    baser_rx_top #(.CNT_W(CNT_W)) baser_rx_top_i (
        .clk (clk), .i_rst (i_rst), .i_valid (i_valid), .i_rx_coded (i_rx_coded),
        .o_valid (o_valid), .o_txd (o_txd), .o_txc (o_txc),
        .o_block_count (o_block_count), .o_data_count (o_data_count),
        .o_ctrl_count (o_ctrl_count), .o_inv_format_count (o_inv_format_count),
        .o_inv_sh_count (o_inv_sh_count), .o_inv_block_count (o_inv_block_count)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Idle character gives MII idle and anything else MII error
    function automatic logic [7:0] expect_lane(input logic [6:0] cc);
        if (cc == 7'h00) begin
            return baser_pkg::MII_IDLE;
        end
        return baser_pkg::MII_ERROR;
    endfunction

    task automatic note_error();
        err_count++;
        test_errs++;
    endtask

    task automatic compare_txd(input string name, input baser_pkg::mii_data_t exp,
                               input baser_pkg::mii_data_t act);
        if (exp !== act) begin
            $display("MISMATCH %s txd: expected %h, actual %h", name, exp, act);
            note_error();
        end
    endtask

    task automatic compare_txc(input string name, input baser_pkg::mii_ctrl_t exp,
                               input baser_pkg::mii_ctrl_t act);
        if (exp !== act) begin
            $display("MISMATCH %s txc: expected %h, actual %h", name, exp, act);
            note_error();
        end
    endtask

    task automatic compare_count(input string name, input logic [CNT_W-1:0] exp,
                                 input logic [CNT_W-1:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
            note_error();
        end
    endtask

    // Pops one expected word per o_valid and checks that outputs hold otherwise
    initial begin
        forever begin
            @(negedge clk);
            if (!i_rst && o_valid) begin
                if (exp_txd_q.size() == 0) begin
                    $display("ERROR %s: o_valid strobe with no block outstanding", cur_test);
                    note_error();
                end else begin
                    compare_txd(cur_test, exp_txd_q.pop_front(), o_txd);
                    compare_txc(cur_test, exp_txc_q.pop_front(), o_txc);
                end
            end else if (!i_rst) begin
                compare_txd({cur_test, " hold"}, last_txd, o_txd);
                compare_txc({cur_test, " hold"}, last_txc, o_txc);
                compare_count({cur_test, " hold block_count"}, last_blocks, o_block_count);
            end
            last_txd    = o_txd;
            last_txc    = o_txc;
            last_blocks = o_block_count;
        end
    end

    task automatic send_block(input baser_pkg::coded_t blk, input baser_pkg::mii_data_t xd,
                              input baser_pkg::mii_ctrl_t xc, input bit fmt);
        logic sh_bad;
        sh_bad = (blk[1:0] != baser_pkg::SH_DATA) && (blk[1:0] != baser_pkg::SH_CTRL);
        exp_txd_q.push_back(xd);
        exp_txc_q.push_back(xc);
        m_blocks = m_blocks + CNT_W'(1);
        if (blk[1:0] == baser_pkg::SH_DATA) begin
            m_data = m_data + CNT_W'(1);
        end else if (blk[1:0] == baser_pkg::SH_CTRL) begin
            m_ctrl = m_ctrl + CNT_W'(1);
        end else begin
            m_sh = m_sh + CNT_W'(1);
        end
        if (fmt) begin
            m_fmt = m_fmt + CNT_W'(1);
        end
        if (fmt || sh_bad) begin
            m_inv = m_inv + CNT_W'(1);
        end
        @(posedge clk);
        i_valid    <= 1'b1;
        i_rx_coded <= blk;
    endtask

    task automatic send_data();
        logic [63:0] d;
        d = rand_bits(64);
        send_block({d, baser_pkg::SH_DATA}, d, 8'h00, 1'b0);
    endtask

    // Lane j character sits in chars[7j +: 7]
    task automatic send_ctrl(input logic [55:0] chars);
        baser_pkg::mii_data_t xd;
        for (int j = 0; j < 8; j++) begin
            xd[8*j +: 8] = expect_lane(chars[7*j +: 7]);
        end
        send_block({chars, baser_pkg::BT_CTRL, baser_pkg::SH_CTRL}, xd, 8'hFF, 1'b0);
    endtask

    // Type byte, k data bytes, 7-k pad bits, then 7-bit characters
    task automatic send_term(input int k, input bit bad_pad);
        logic [63:0]          p;
        baser_pkg::mii_data_t xd;
        baser_pkg::mii_ctrl_t xc;
        logic [7:0]           b;
        logic [6:0]           cc;
        int                   pos;
        p      = '0;
        p[7:0] = TERM_TYPES[k];
        pos    = 8;
        for (int i = 0; i < k; i++) begin
            b            = 8'(rand_bits(8));
            p[pos +: 8]  = b;
            xd[8*i +: 8] = b;
            pos += 8;
        end
        xd[8*k +: 8] = baser_pkg::MII_TERM;
        if (bad_pad) begin
            p[pos] = 1'b1;
        end
        pos += 7 - k;
        for (int j = k + 1; j < 8; j++) begin
            cc           = (rand_bits(1) != '0) ? 7'h00 : 7'(rand_bits(7));
            p[pos +: 7]  = cc;
            xd[8*j +: 8] = expect_lane(cc);
            pos += 7;
        end
        for (int j = 0; j < 8; j++) begin
            xc[j] = (j >= k);
        end
        send_block({p, baser_pkg::SH_CTRL}, xd, xc, bad_pad);
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic check_counts();
        compare_count({cur_test, " block_count"}, m_blocks, o_block_count);
        compare_count({cur_test, " data_count"}, m_data, o_data_count);
        compare_count({cur_test, " ctrl_count"}, m_ctrl, o_ctrl_count);
        compare_count({cur_test, " inv_format_count"}, m_fmt, o_inv_format_count);
        compare_count({cur_test, " inv_sh_count"}, m_sh, o_inv_sh_count);
        compare_count({cur_test, " inv_block_count"}, m_inv, o_inv_block_count);
        compare_count({cur_test, " inv sum"}, m_fmt + m_sh, o_inv_block_count);
    endtask

    task automatic report_test();
        tests_run++;
        if (test_errs != 0) begin
            tests_failed++;
        end
        $display("test %-10s %s (%0d errors)", cur_test, (test_errs == 0) ? "ok" : "FAILED",
                 test_errs);
    endtask

    // Stop driving, wait for every word, then check the counters
    task automatic end_test();
        int n;
        @(posedge clk);
        i_valid <= 1'b0;
        n = 0;
        while (exp_txd_q.size() != 0 && n < DRAIN_CYC) begin
            @(negedge clk);
            n++;
        end
        if (exp_txd_q.size() != 0) begin
            $display("ERROR %s: %0d decoded words never came out", cur_test, exp_txd_q.size());
            note_error();
        end
        @(negedge clk);
        check_counts();
        report_test();
    endtask

    task automatic test_reset();
        start_test("reset");
        @(negedge clk);
        if (o_valid !== 1'b0) begin
            $display("ERROR reset: o_valid is not low after reset");
            note_error();
        end
        compare_txd(cur_test, '0, o_txd);
        compare_txc(cur_test, '0, o_txc);
        check_counts();
        report_test();
    endtask

    task automatic test_data();
        start_test("data");
        repeat (16) send_data();
        end_test();
    endtask

    task automatic test_ctrl();
        logic [55:0] mix;
        start_test("ctrl");
        send_ctrl('0);
        send_ctrl({8{7'h1E}});
        send_ctrl({4{7'h2D, 7'h00}});
        for (int j = 0; j < 8; j++) begin
            mix[7*j +: 7] = (rand_bits(1) != '0) ? 7'h00 : 7'(rand_bits(7));
        end
        send_ctrl(mix);
        end_test();
    endtask

    task automatic test_start_term();
        logic [55:0] d;
        start_test("start_term");
        d = 56'(rand_bits(56));
        send_block({d, baser_pkg::BT_START, baser_pkg::SH_CTRL},
                   {d, baser_pkg::MII_START}, 8'h01, 1'b0);
        for (int k = 0; k < 8; k++) begin
            send_term(k, 1'b0);
        end
        end_test();
    endtask

    task automatic test_errors();
        start_test("errors");
        send_block({rand_bits(64), 2'b00}, {8{baser_pkg::MII_ERROR}}, 8'hFF, 1'b0);
        send_block({rand_bits(64), 2'b11}, {8{baser_pkg::MII_ERROR}}, 8'hFF, 1'b0);
        send_block({56'(rand_bits(56)), 8'h4B, baser_pkg::SH_CTRL},
                   {8{baser_pkg::MII_ERROR}}, 8'hFF, 1'b1);
        send_block({56'(rand_bits(56)), 8'h2D, baser_pkg::SH_CTRL},
                   {8{baser_pkg::MII_ERROR}}, 8'hFF, 1'b1);
        send_term(2, 1'b1);
        end_test();
    endtask

    task automatic test_gaps();
        int gap;
        start_test("gaps");
        for (int i = 0; i < 8; i++) begin
            if (i[0]) begin
                send_ctrl(56'(rand_bits(56)));
            end else begin
                send_data();
            end
            gap = int'(rand_bits(2));
            repeat (gap) begin
                @(posedge clk);
                i_valid <= 1'b0;
            end
        end
        end_test();
    endtask

    initial begin
        #((TEST_BLOCKS + MARGIN_CYC) * CLK_PERIOD);
        $display("ERROR watchdog: the run did not finish in time");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int assert_fails;
        i_rst      <= 1'b1;
        i_valid    <= 1'b0;
        i_rx_coded <= '0;
        repeat (4) @(posedge clk);
        i_rst <= 1'b0;
        test_reset();
        test_data();
        test_ctrl();
        test_start_term();
        test_errors();
        test_gaps();
        assert_fails = int'(baser_rx_top_i.baser_rx_assertions_i.fail_count);
        $display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, err_count, assert_fails);
        if (err_count == 0 && tests_failed == 0 && assert_fails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
common/baser_pkg.sv
common/blk_if.sv
decode/block_classifier.sv
decode/mii_mapper.sv
hdl/rx_stats.sv
hdl/baser_rx_top.sv
sim/baser_rx_assertions.sv
sim/tb_baser_rx.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_baser_rx \
    -Mdir obj_dir -o tb_baser_rx > "$BUILD_LOG" 2>&1
build_status=$?
cat "$BUILD_LOG"
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_baser_rx +verilator+error+limit+100 > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "All tests passed" "$SIM_LOG"; then
    exit 0
fi
echo "Pass message not found in $SIM_LOG"
exit 1
